//--- eeprom_pkg.sv
package eeprom_pkg;

    // upper four bits of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // 8 blocks of 256 bytes
    localparam int ADDR_W    = 11;
    localparam int DATA_W    = 8;
    localparam int MEM_DEPTH = 2048;

    // address bits that roll over inside a page write
    localparam int PAGE_W = 4;

    localparam int SYNC_STAGES = 2;

    typedef enum logic [3:0] {
        IDLE,
        CTRL,
        CTRL_ACK,
        ADDR,
        ADDR_ACK,
        WDATA,
        WDATA_ACK,
        RDATA,
        RDATA_ACK,
        IGNORE
    } proto_state_t;

endpackage

//--- bus_event_if.sv
`timescale 1ns/1ps

interface bus_event_if;

    // single-cycle pulses, all aligned to the same sampling delay
    logic clk_rise;
    logic clk_fall;
    logic start;
    logic stop;

    // synchronized data line level
    logic data_bit;

    modport sampler (
        output clk_rise,
        output clk_fall,
        output data_bit,
        output start,
        output stop
    );

    modport proto (
        input clk_rise,
        input clk_fall,
        input data_bit,
        input start,
        input stop
    );

endinterface

//--- mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;

    logic                          we;
    logic                          re;
    logic [eeprom_pkg::ADDR_W-1:0] addr;
    logic [eeprom_pkg::DATA_W-1:0] wdata;
    // valid one cycle after re, held until the next re
    logic [eeprom_pkg::DATA_W-1:0] rdata;

    modport ctrl (
        output we,
        output re,
        output addr,
        output wdata,
        input  rdata
    );

    modport mem (
        input  we,
        input  re,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- bus_sampler.sv
`timescale 1ns/1ps

module bus_sampler (
    input  logic        scl,
    input  logic        rst_n,
    input  logic        ser_clk,
    input  logic        ser_data,
    bus_event_if.sampler ev
);

    logic [eeprom_pkg::SYNC_STAGES-1:0] clk_sync;
    logic [eeprom_pkg::SYNC_STAGES-1:0] data_sync;
    logic                               clk_prev;
    logic                               data_prev;
    logic                               clk_s;
    logic                               data_s;

    assign clk_s  = clk_sync[eeprom_pkg::SYNC_STAGES-1];
    assign data_s = data_sync[eeprom_pkg::SYNC_STAGES-1];

    // previous sample doubles as the delayed data level
    assign ev.data_bit = data_prev;

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // idle bus has both lines high
            clk_sync    <= '1;
            data_sync   <= '1;
            clk_prev    <= 1'b1;
            data_prev   <= 1'b1;
            ev.clk_rise <= 1'b0;
            ev.clk_fall <= 1'b0;
            ev.start    <= 1'b0;
            ev.stop     <= 1'b0;
        end
        else
        begin
            clk_sync  <= {clk_sync[eeprom_pkg::SYNC_STAGES-2:0], ser_clk};
            data_sync <= {data_sync[eeprom_pkg::SYNC_STAGES-2:0], ser_data};
            clk_prev  <= clk_s;
            data_prev <= data_s;

            ev.clk_rise <= clk_s & ~clk_prev;
            ev.clk_fall <= ~clk_s & clk_prev;

            // clock high in both samples, so never alongside a clock edge
            ev.start <= clk_s & clk_prev & data_prev & ~data_s;
            ev.stop  <= clk_s & clk_prev & ~data_prev & data_s;
        end
    end

endmodule

//--- eeprom_protocol.sv
`timescale 1ns/1ps

module eeprom_protocol (
    input  logic        scl,
    input  logic        rst_n,
    bus_event_if.proto  ev,
    mem_port_if.ctrl    mem,
    output logic        sda_pull
);

    eeprom_pkg::proto_state_t state;

    logic [3:0]                    bit_cnt;
    logic [eeprom_pkg::DATA_W-1:0] shift;
    logic [eeprom_pkg::ADDR_W-1:0] ptr;
    logic                          rd_mode;
    logic                          byte_done;
    logic                          last_bit;
    logic                          code_ok;

    assign byte_done = (bit_cnt == 4'd8);
    assign last_bit  = (bit_cnt == 4'd7);
    assign code_ok   = (shift[7:4] == eeprom_pkg::DEVICE_CODE);

    assign mem.addr  = ptr;
    assign mem.wdata = shift;

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= eeprom_pkg::IDLE;
            bit_cnt  <= 4'd0;
            shift    <= '0;
            ptr      <= '0;
            rd_mode  <= 1'b0;
            sda_pull <= 1'b0;
            mem.we   <= 1'b0;
            mem.re   <= 1'b0;
        end
        else
        begin
            mem.we <= 1'b0;
            mem.re <= 1'b0;

            // pointer moves in the cycle the request reaches the array
            if (mem.we)
            begin
                ptr <= {ptr[eeprom_pkg::ADDR_W-1:eeprom_pkg::PAGE_W],
                        ptr[eeprom_pkg::PAGE_W-1:0] +
                        {{(eeprom_pkg::PAGE_W-1){1'b0}}, 1'b1}};
            end
            if (mem.re)
            begin
                ptr <= ptr + {{(eeprom_pkg::ADDR_W-1){1'b0}}, 1'b1};
            end

            if (ev.stop)
            begin
                state    <= eeprom_pkg::IDLE;
                sda_pull <= 1'b0;
            end
            else if (ev.start)
            begin
                state    <= eeprom_pkg::CTRL;
                bit_cnt  <= 4'd0;
                sda_pull <= 1'b0;
            end
            else
            begin
                case (state)
                    eeprom_pkg::CTRL,
                    eeprom_pkg::ADDR,
                    eeprom_pkg::WDATA:
                    begin
                        if (ev.clk_rise)
                        begin
                            shift   <= {shift[eeprom_pkg::DATA_W-2:0], ev.data_bit};
                            bit_cnt <= bit_cnt + 4'd1;
                            if (state == eeprom_pkg::WDATA && last_bit)
                            begin
                                mem.we <= 1'b1;
                            end
                        end
                        else if (ev.clk_fall && byte_done)
                        begin
                            sda_pull <= 1'b1;
                            if (state == eeprom_pkg::CTRL)
                            begin
                                if (code_ok)
                                begin
                                    state   <= eeprom_pkg::CTRL_ACK;
                                    rd_mode <= shift[0];
                                    // a read keeps the pointer, so random read works
                                    if (!shift[0])
                                    begin
                                        ptr[eeprom_pkg::ADDR_W-1:eeprom_pkg::DATA_W] <=
                                            shift[3:1];
                                    end
                                end
                                else
                                begin
                                    state    <= eeprom_pkg::IGNORE;
                                    sda_pull <= 1'b0;
                                end
                            end
                            else if (state == eeprom_pkg::ADDR)
                            begin
                                state <= eeprom_pkg::ADDR_ACK;
                                ptr[eeprom_pkg::DATA_W-1:0] <= shift;
                            end
                            else
                            begin
                                state <= eeprom_pkg::WDATA_ACK;
                            end
                        end
                    end

                    eeprom_pkg::CTRL_ACK:
                    begin
                        if (ev.clk_rise && rd_mode)
                        begin
                            mem.re <= 1'b1;
                        end
                        else if (ev.clk_fall)
                        begin
                            bit_cnt <= 4'd0;
                            if (rd_mode)
                            begin
                                state    <= eeprom_pkg::RDATA;
                                shift    <= mem.rdata;
                                sda_pull <= ~mem.rdata[eeprom_pkg::DATA_W-1];
                            end
                            else
                            begin
                                state    <= eeprom_pkg::ADDR;
                                sda_pull <= 1'b0;
                            end
                        end
                    end

                    eeprom_pkg::ADDR_ACK,
                    eeprom_pkg::WDATA_ACK:
                    begin
                        if (ev.clk_fall)
                        begin
                            state    <= eeprom_pkg::WDATA;
                            bit_cnt  <= 4'd0;
                            sda_pull <= 1'b0;
                        end
                    end

                    eeprom_pkg::RDATA:
                    begin
                        if (ev.clk_rise)
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                        else if (ev.clk_fall)
                        begin
                            if (byte_done)
                            begin
                                // let the master drive its ack
                                state    <= eeprom_pkg::RDATA_ACK;
                                sda_pull <= 1'b0;
                            end
                            else
                            begin
                                shift    <= {shift[eeprom_pkg::DATA_W-2:0], 1'b0};
                                sda_pull <= ~shift[eeprom_pkg::DATA_W-2];
                            end
                        end
                    end

                    eeprom_pkg::RDATA_ACK:
                    begin
                        if (ev.clk_rise)
                        begin
                            if (ev.data_bit)
                            begin
                                state <= eeprom_pkg::IDLE;
                            end
                            else
                            begin
                                mem.re <= 1'b1;
                            end
                        end
                        else if (ev.clk_fall)
                        begin
                            state    <= eeprom_pkg::RDATA;
                            bit_cnt  <= 4'd0;
                            shift    <= mem.rdata;
                            sda_pull <= ~mem.rdata[eeprom_pkg::DATA_W-1];
                        end
                    end

                    // IDLE and IGNORE only leave on start or stop
                    default:
                    begin
                        sda_pull <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

//--- eeprom_array.sv
`timescale 1ns/1ps

module eeprom_array (
    input  logic     scl,
    mem_port_if.mem  mem
);

    logic [eeprom_pkg::DATA_W-1:0] store [eeprom_pkg::MEM_DEPTH];

    always_ff @(posedge scl)
    begin
        if (mem.we)
        begin
            store[mem.addr] <= mem.wdata;
        end
    end

    // registered read, held between requests
    always_ff @(posedge scl)
    begin
        if (mem.re)
        begin
            mem.rdata <= store[mem.addr];
        end
    end

endmodule

//--- eeprom_top.sv
`timescale 1ns/1ps

module eeprom_top (
    input  logic scl,
    input  logic rst_n,
    input  logic ser_clk,
    input  logic ser_data,
    output logic sda_pull
);

    bus_event_if u_ev ();
    mem_port_if  u_mem ();

    bus_sampler u_sampler (
        .scl      (scl),
        .rst_n    (rst_n),
        .ser_clk  (ser_clk),
        .ser_data (ser_data),
        .ev       (u_ev.sampler)
    );

    eeprom_protocol u_protocol (
        .scl      (scl),
        .rst_n    (rst_n),
        .ev       (u_ev.proto),
        .mem      (u_mem.ctrl),
        .sda_pull (sda_pull)
    );

    eeprom_array u_array (
        .scl (scl),
        .mem (u_mem.mem)
    );

endmodule

//--- eeprom_checker.sv
`timescale 1ns/1ps

module eeprom_checker (
    input logic                     scl,
    input logic                     rst_n,
    input eeprom_pkg::proto_state_t state,
    input logic                     sda_pull,
    input logic                     clk_fall,
    input logic                     start,
    input logic                     stop,
    input logic                     we,
    input logic                     re
);

    // drive bit only moves after a falling bus clock or a bus condition
    assert property (@(posedge scl) disable iff (!rst_n)
        (sda_pull != $past(sda_pull)) |-> ($past(clk_fall) || $past(start) || $past(stop)))
        else $error("sda_pull changed outside its update window");

    assert property (@(posedge scl) disable iff (!rst_n)
        we |-> (state == eeprom_pkg::WDATA))
        else $error("memory write issued outside WDATA");

    assert property (@(posedge scl) disable iff (!rst_n)
        !(we && re))
        else $error("read and write requested together");

    assert property (@(posedge scl) disable iff (!rst_n)
        stop |=> (state == eeprom_pkg::IDLE))
        else $error("state not IDLE after stop");

endmodule

bind eeprom_protocol eeprom_checker u_checker (
    .scl      (scl),
    .rst_n    (rst_n),
    .state    (state),
    .sda_pull (sda_pull),
    .clk_fall (ev.clk_fall),
    .start    (ev.start),
    .stop     (ev.stop),
    .we       (mem.we),
    .re       (mem.re)
);

//--- tb_eeprom.sv
`timescale 1ns/1ps

module tb_eeprom;

    logic       scl;
    logic       rst_n;
    logic       ser_clk;
    logic       drv_data;
    logic       ser_data;
    logic       sda_pull;
    logic [7:0] model [2048];
    logic [7:0] wr_bytes [$];

    // open-drain line, high only when neither side pulls
    assign ser_data = drv_data & ~sda_pull;

    eeprom_top u_dut (
        .scl      (scl),
        .rst_n    (rst_n),
        .ser_clk  (ser_clk),
        .ser_data (ser_data),
        .sda_pull (sda_pull)
    );

    always #20 scl = ~scl;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // n clock edges, then 1 ns past the last one
    task automatic step(input int n);
        repeat (n) @(posedge scl);
        #1;
    endtask

    task automatic wait_released(input int limit);
        int n;
        n = 0;
        while (ser_data !== 1'b1 && n < limit)
        begin
            step(1);
            n++;
        end
        assert (ser_data === 1'b1)
        else abort_run("timeout waiting for the data line to be released");
    endtask

    // one bus clock period, 10 cycles per phase, sampled mid high phase
    task automatic clock_bit(input logic level, output logic sampled);
        drv_data = level;
        step(5);
        ser_clk = 1'b1;
        step(5);
        sampled = ser_data;
        step(5);
        ser_clk = 1'b0;
        step(5);
    endtask

    task automatic bus_start();
        if (!ser_clk)
        begin
            drv_data = 1'b1;
            step(5);
            ser_clk = 1'b1;
            step(5);
        end
        wait_released(20);
        drv_data = 1'b0;
        step(5);
        ser_clk = 1'b0;
        step(5);
    endtask

    task automatic bus_stop();
        drv_data = 1'b0;
        step(5);
        ser_clk = 1'b1;
        step(5);
        drv_data = 1'b1;
        step(10);
    endtask

    task automatic write_byte(input logic [7:0] b, output logic ack);
        logic s;
        int   i;
        for (i = 7; i >= 0; i--)
        begin
            clock_bit(b[i], s);
        end
        clock_bit(1'b1, s);
        ack = ~s;
    endtask

    task automatic read_byte(input logic ack, output logic [7:0] b);
        logic s;
        int   i;
        for (i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, s);
            b[i] = s;
        end
        clock_bit(~ack, s);
    endtask

    task automatic send_checked(input logic [7:0] b, input string what);
        logic ack;
        write_byte(b, ack);
        assert (ack === 1'b1)
        else abort_run($sformatf("slave did not acknowledge the %s", what));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else abort_run($sformatf("ERROR: %s got 0x%02h expected 0x%02h", name, got, exp));
    endtask

    task automatic fill_random(input int n);
        wr_bytes.delete();
        repeat (n) wr_bytes.push_back(8'($urandom));
    endtask

    task automatic page_write(input logic [10:0] addr);
        logic [10:0] a;
        a = addr;
        bus_start();
        send_checked({4'b1010, addr[10:8], 1'b0}, "write control byte");
        send_checked(addr[7:0], "address byte");
        foreach (wr_bytes[i])
        begin
            send_checked(wr_bytes[i], "data byte");
            model[a] = wr_bytes[i];
            // pointer rolls over inside the 16-byte page
            a[3:0] = a[3:0] + 4'd1;
        end
        bus_stop();
    endtask

    // master acks every byte but the last
    task automatic current_read(input logic [10:0] addr, input int count);
        logic [7:0]  got;
        logic [10:0] a;
        int          i;
        a = addr;
        bus_start();
        send_checked({4'b1010, addr[10:8], 1'b1}, "read control byte");
        for (i = 0; i < count; i++)
        begin
            read_byte(i < count - 1, got);
            check_byte($sformatf("read data at 0x%03h", a), got, model[a]);
            a = a + 11'd1;
        end
        bus_stop();
    endtask

    // dummy write sets the pointer, then a repeated start
    task automatic read_from(input logic [10:0] addr, input int count);
        bus_start();
        send_checked({4'b1010, addr[10:8], 1'b0}, "write control byte");
        send_checked(addr[7:0], "address byte");
        current_read(addr, count);
    endtask

    task automatic foreign_code_ignored();
        logic ack;
        assert (sda_pull === 1'b0)
        else abort_run($sformatf("ERROR: sda_pull got 0x%h expected 0x0", sda_pull));
        bus_start();
        write_byte(8'b1011_0000, ack);
        assert (ack === 1'b0)
        else abort_run("slave acknowledged a control byte with device code 1011");
        write_byte(8'($urandom), ack);
        assert (ack === 1'b0)
        else abort_run("slave acknowledged a byte after a foreign control byte");
        bus_stop();
    endtask

    task automatic single_write_readback();
        logic [10:0] a;
        a = {3'd5, 8'($urandom)};
        fill_random(1);
        page_write(a);
        read_from(a, 1);
    endtask

    task automatic page_rollover();
        logic [10:0] a;
        a = {3'd2, 4'($urandom), 4'd12};
        fill_random(20);
        page_write(a);
        read_from({a[10:4], 4'd0}, 16);
    endtask

    // reads 2045 up to 2, leaving the pointer at 3
    task automatic read_past_top();
        fill_random(3);
        page_write(11'd2045);
        fill_random(4);
        page_write(11'd0);
        read_from(11'd2045, 6);
    endtask

    task automatic separate_blocks();
        logic [7:0] low;
        logic [7:0] v;
        low = 8'($urandom);
        v   = 8'($urandom);
        wr_bytes.delete();
        wr_bytes.push_back(v);
        page_write({3'd0, low});
        wr_bytes.delete();
        wr_bytes.push_back(~v);
        page_write({3'd7, low});
        read_from({3'd0, low}, 1);
        read_from({3'd7, low}, 1);
    endtask

    initial
    begin
        scl      = 1'b0;
        rst_n    = 1'b0;
        ser_clk  = 1'b1;
        drv_data = 1'b1;
        void'($urandom(86));
        step(3);
        rst_n = 1'b1;
        step(2);
        foreign_code_ignored();
        single_write_readback();
        page_rollover();
        read_past_top();
        current_read(11'd3, 1);
        separate_blocks();
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- sources.f
eeprom_pkg.sv
bus_event_if.sv
mem_port_if.sv
bus_sampler.sv
eeprom_protocol.sv
eeprom_array.sv
eeprom_top.sv
eeprom_checker.sv
tb_eeprom.sv

//--- Makefile
TOP = tb_eeprom

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
